// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

	typedef logic [15:0] instr_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  sel_t;
	typedef logic [2:0]  jump_sel_t;
	typedef logic [1:0]  flow_req_t;

	// instruction classes, bits 15:14
	localparam logic [1:0] CLS_ALU    = 2'b00;
	localparam logic [1:0] CLS_ONE_OP = 2'b01;
	localparam logic [1:0] CLS_TWO_OP = 2'b10;
	localparam logic [1:0] CLS_BRANCH = 2'b11;

	localparam alu_op_t ALU_NOT  = 4'd0;
	localparam alu_op_t ALU_INC  = 4'd1;
	localparam alu_op_t ALU_DEC  = 4'd2;
	localparam alu_op_t ALU_ADD  = 4'd3;
	localparam alu_op_t ALU_SUB  = 4'd4;
	localparam alu_op_t ALU_AND  = 4'd5;
	localparam alu_op_t ALU_OR   = 4'd6;
	localparam alu_op_t ALU_SHL  = 4'd7;
	localparam alu_op_t ALU_SHR  = 4'd8;
	localparam alu_op_t ALU_PASS = 4'd15;

	localparam sel_t CARRY_SET    = 2'd1;
	localparam sel_t CARRY_CLR    = 2'd2;
	localparam sel_t MEM_ADDR_REG = 2'd1;
	localparam sel_t MEM_ADDR_SP  = 2'd2;
	localparam sel_t MEM_DATA_REG = 2'd3;
	localparam sel_t WB_IMM       = 2'd0;
	localparam sel_t WB_MEM       = 2'd1;
	localparam sel_t WB_ALU       = 2'd2;

	// what the datapath puts on the stack
	localparam sel_t STK_FLAGS = 2'd0;
	localparam sel_t STK_PC_HI = 2'd1;
	localparam sel_t STK_PC_LO = 2'd2;

	localparam jump_sel_t JUMP_ALWAYS = 3'b111;

	localparam flow_req_t FLOW_NONE = 2'd0;
	localparam flow_req_t FLOW_CALL = 2'd1;
	localparam flow_req_t FLOW_RET  = 2'd2;
	localparam flow_req_t FLOW_RETI = 2'd3;

	typedef struct packed {
		logic pc_write;
		logic inport_sel;
		logic clear_instruction;
		logic pc_from_mem;
	} fetch_ctrl_t;

	typedef struct packed {
		alu_op_t   alu_op;
		sel_t      alu_src1_sel;
		sel_t      alu_src2_sel;
		jump_sel_t jump_sel;
		sel_t      carry_sel;
		logic      flag_restore;
		logic      flag_write;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic mem_push;
		logic mem_pop;
		sel_t mem_addr_sel;
		sel_t mem_data_sel;
		sel_t stack_src;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		sel_t wb_sel;
		logic out_enable;
	} wb_ctrl_t;

	typedef enum logic [3:0] {
		IDLE,
		PIPE_DRAIN,
		PUSH_PC_HI,
		PUSH_PC_LO,
		PUSH_FLAGS,
		CALL_PUSH_LO,
		POP_FLAGS,
		POP_PC_HI,
		POP_PC_LO,
		LOAD_WAIT
	} seq_state_e;

endpackage

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
	import ctrl_pkg::*;
(
	input  instr_t      instruction,
	output fetch_ctrl_t dec_fetch,
	output ex_ctrl_t    dec_ex,
	output mem_ctrl_t   dec_mem,
	output wb_ctrl_t    dec_wb,
	output flow_req_t   flow_req
);

	logic [1:0] op_class;
	logic [2:0] func;
	logic       dec_mod;

	assign op_class = instruction[15:14];
	assign func     = instruction[13:11];
	assign dec_mod  = instruction[10];

	always_comb
	begin
		// start from a NOP, then set what the op needs
		dec_fetch          = '0;
		dec_ex             = '0;
		dec_mem            = '0;
		dec_wb             = '0;
		flow_req           = FLOW_NONE;
		dec_fetch.pc_write = 1'b1;
		dec_ex.alu_op      = ALU_PASS;

		case (op_class)
			CLS_ALU:
			begin
				dec_ex.flag_write = 1'b1;
				dec_wb.reg_write  = 1'b1;
				dec_wb.wb_sel     = WB_ALU;
				case (func)
					3'd0: dec_ex.alu_op = ALU_NOT;
					// bit 10 picks DEC over INC
					3'd1: dec_ex.alu_op = dec_mod ? ALU_DEC : ALU_INC;
					3'd2: dec_ex.alu_op = ALU_ADD;
					3'd3: dec_ex.alu_op = ALU_SUB;
					3'd4: dec_ex.alu_op = ALU_AND;
					3'd5: dec_ex.alu_op = ALU_OR;
					3'd6: dec_ex.alu_op = ALU_SHL;
					default: dec_ex.alu_op = ALU_SHR;
				endcase
			end

			CLS_ONE_OP:
			begin
				case (func)
					// setc / clrc
					3'd1:
					begin
						dec_ex.carry_sel  = CARRY_SET;
						dec_ex.flag_write = 1'b1;
					end
					3'd2:
					begin
						dec_ex.carry_sel  = CARRY_CLR;
						dec_ex.flag_write = 1'b1;
					end
					3'd3: dec_wb.out_enable = 1'b1;
					3'd4:
					begin
						dec_fetch.inport_sel = 1'b1;
						dec_wb.reg_write     = 1'b1;
					end
					// push
					3'd5:
					begin
						dec_mem.mem_write    = 1'b1;
						dec_mem.mem_push     = 1'b1;
						dec_mem.mem_addr_sel = MEM_ADDR_SP;
						dec_mem.mem_data_sel = MEM_DATA_REG;
					end
					// pop
					3'd6:
					begin
						dec_mem.mem_read     = 1'b1;
						dec_mem.mem_pop      = 1'b1;
						dec_mem.mem_addr_sel = MEM_ADDR_SP;
						dec_wb.reg_write     = 1'b1;
						dec_wb.wb_sel        = WB_MEM;
					end
					default: ;
				endcase
			end

			CLS_TWO_OP:
			begin
				case (func)
					// mov goes through the ALU unchanged
					3'd0:
					begin
						dec_wb.reg_write = 1'b1;
						dec_wb.wb_sel    = WB_ALU;
					end
					3'd1:
					begin
						dec_wb.reg_write = 1'b1;
						dec_wb.wb_sel    = WB_IMM;
					end
					3'd2:
					begin
						dec_mem.mem_read     = 1'b1;
						dec_mem.mem_addr_sel = MEM_ADDR_REG;
						dec_wb.reg_write     = 1'b1;
						dec_wb.wb_sel        = WB_MEM;
					end
					// std and the rest stay NOP
					default: ;
				endcase
			end

			default:
			begin
				case (func)
					// conditional and unconditional jumps
					3'd0, 3'd1, 3'd2, 3'd3: dec_ex.jump_sel = {1'b1, func[1:0]};
					// call, high PC half goes first
					3'd4:
					begin
						dec_mem.mem_push  = 1'b1;
						dec_mem.stack_src = STK_PC_HI;
						dec_ex.jump_sel   = JUMP_ALWAYS;
						flow_req          = FLOW_CALL;
					end
					3'd5:
					begin
						dec_mem.mem_pop = 1'b1;
						flow_req        = FLOW_RET;
					end
					3'd6: flow_req = FLOW_RETI;
					default: ;
				endcase
			end
		endcase
	end

	push_pop_excl: assert final (!(dec_mem.mem_push && dec_mem.mem_pop))
		else $error("decoder drives push and pop together");

endmodule

// File: rtl/flow_sequencer.sv
`timescale 1ns/1ps

module flow_sequencer
	import ctrl_pkg::*;
#(
	parameter int DRAIN_CYCLES = 5,
	parameter int MEM_LATENCY  = 2
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        irq,
	input  fetch_ctrl_t dec_fetch,
	input  ex_ctrl_t    dec_ex,
	input  mem_ctrl_t   dec_mem,
	input  wb_ctrl_t    dec_wb,
	input  flow_req_t   flow_req,
	output fetch_ctrl_t fetch_ctrl,
	output ex_ctrl_t    ex_ctrl,
	output mem_ctrl_t   mem_ctrl,
	output wb_ctrl_t    wb_ctrl
);

	localparam int CNT_MAX = (DRAIN_CYCLES > MEM_LATENCY) ? DRAIN_CYCLES : MEM_LATENCY;
	localparam int CNT_W   = (CNT_MAX > 1) ? $clog2(CNT_MAX + 1) : 1;

	// last counter value in each counted state
	localparam logic [CNT_W-1:0] DRAIN_LAST = CNT_W'(DRAIN_CYCLES - 1);
	localparam logic [CNT_W-1:0] WAIT_LAST  = CNT_W'(MEM_LATENCY);

	seq_state_e       state;
	seq_state_e       state_next;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= IDLE;
			cnt   <= '0;
		end
		else
		begin
			state <= state_next;
			cnt   <= cnt_next;
		end
	end

	always_comb
	begin
		state_next = state;
		cnt_next   = '0;
		case (state)
			IDLE:
			begin
				// interrupt wins over any flow request
				if (irq)
					state_next = PIPE_DRAIN;
				else if (flow_req == FLOW_CALL)
					state_next = CALL_PUSH_LO;
				else if (flow_req == FLOW_RET)
					state_next = POP_PC_LO;
				else if (flow_req == FLOW_RETI)
					state_next = POP_FLAGS;
			end
			PIPE_DRAIN:
			begin
				if (cnt == DRAIN_LAST)
					state_next = PUSH_PC_HI;
				else
					cnt_next = cnt + 1'b1;
			end
			PUSH_PC_HI:   state_next = PUSH_PC_LO;
			PUSH_PC_LO:   state_next = PUSH_FLAGS;
			POP_FLAGS:    state_next = POP_PC_HI;
			POP_PC_HI:    state_next = POP_PC_LO;
			POP_PC_LO:    state_next = LOAD_WAIT;
			LOAD_WAIT:
			begin
				if (cnt == WAIT_LAST)
					state_next = IDLE;
				else
					cnt_next = cnt + 1'b1;
			end
			default:      state_next = IDLE;
		endcase
	end

	always_comb
	begin
		// sequencer cycles are bubbles unless a field is set below
		fetch_ctrl     = '0;
		ex_ctrl        = '0;
		ex_ctrl.alu_op = ALU_PASS;
		mem_ctrl       = '0;
		wb_ctrl        = '0;
		case (state)
			IDLE:
			begin
				if (irq)
					fetch_ctrl.clear_instruction = 1'b1;
				else
				begin
					fetch_ctrl = dec_fetch;
					ex_ctrl    = dec_ex;
					mem_ctrl   = dec_mem;
					wb_ctrl    = dec_wb;
				end
			end
			PIPE_DRAIN: fetch_ctrl.clear_instruction = 1'b1;
			PUSH_PC_HI:
			begin
				mem_ctrl.mem_push  = 1'b1;
				mem_ctrl.stack_src = STK_PC_HI;
			end
			// second half of the return address, interrupt or call
			PUSH_PC_LO, CALL_PUSH_LO:
			begin
				mem_ctrl.mem_push  = 1'b1;
				mem_ctrl.stack_src = STK_PC_LO;
			end
			PUSH_FLAGS:
			begin
				mem_ctrl.mem_push  = 1'b1;
				mem_ctrl.stack_src = STK_FLAGS;
			end
			POP_FLAGS:
			begin
				mem_ctrl.mem_pop     = 1'b1;
				ex_ctrl.flag_restore = 1'b1;
			end
			POP_PC_HI, POP_PC_LO: mem_ctrl.mem_pop = 1'b1;
			// popped PC arrives after the memory latency
			LOAD_WAIT: fetch_ctrl.pc_from_mem = (cnt == WAIT_LAST);
			default: ;
		endcase
	end

	cnt_in_range: assert property (@(posedge clk) disable iff (!reset)
		(state == PIPE_DRAIN) ? (cnt <= DRAIN_LAST) :
		(state == LOAD_WAIT)  ? (cnt <= WAIT_LAST)  : (cnt == '0))
		else $error("counter out of range in %s", state.name());

	no_push_pop: assert property (@(posedge clk) disable iff (!reset)
		!(mem_ctrl.mem_push && mem_ctrl.mem_pop))
		else $error("push and pop asserted together");

	from_mem_in_wait: assert property (@(posedge clk) disable iff (!reset)
		fetch_ctrl.pc_from_mem |-> (state == LOAD_WAIT))
		else $error("pc_from_mem outside LOAD_WAIT");

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit
	import ctrl_pkg::*;
#(
	parameter int DRAIN_CYCLES = 5,
	parameter int MEM_LATENCY  = 2
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        irq,
	input  instr_t      instruction,
	output fetch_ctrl_t fetch_ctrl,
	output ex_ctrl_t    ex_ctrl,
	output mem_ctrl_t   mem_ctrl,
	output wb_ctrl_t    wb_ctrl
);

	// decoded bundles, valid in the same cycle as the instruction
	fetch_ctrl_t dec_fetch;
	ex_ctrl_t    dec_ex;
	mem_ctrl_t   dec_mem;
	wb_ctrl_t    dec_wb;
	flow_req_t   flow_req;

	instr_decoder u_decoder (
		.instruction (instruction),
		.dec_fetch   (dec_fetch),
		.dec_ex      (dec_ex),
		.dec_mem     (dec_mem),
		.dec_wb      (dec_wb),
		.flow_req    (flow_req)
	);

	flow_sequencer #(
		.DRAIN_CYCLES (DRAIN_CYCLES),
		.MEM_LATENCY  (MEM_LATENCY)
	) u_sequencer (
		.clk        (clk),
		.reset      (reset),
		.irq        (irq),
		.dec_fetch  (dec_fetch),
		.dec_ex     (dec_ex),
		.dec_mem    (dec_mem),
		.dec_wb     (dec_wb),
		.flow_req   (flow_req),
		.fetch_ctrl (fetch_ctrl),
		.ex_ctrl    (ex_ctrl),
		.mem_ctrl   (mem_ctrl),
		.wb_ctrl    (wb_ctrl)
	);

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 100
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// held low over the first two rising edges
	initial
	begin
		reset = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b1;
	end

endmodule

// File: verif/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit
	import ctrl_pkg::*;
();

	localparam int    CLK_PERIOD   = 100;
	localparam string PATTERN_FILE = "verif/control_patterns.txt";

	logic        clk;
	logic        reset;
	logic        irq;
	instr_t      instruction;
	fetch_ctrl_t fetch_ctrl;
	ex_ctrl_t    ex_ctrl;
	mem_ctrl_t   mem_ctrl;
	wb_ctrl_t    wb_ctrl;

	// one entry per pattern line
	string       pat_name[$];
	logic [15:0] pat_instr[$];
	logic        pat_irq[$];
	logic [32:0] pat_expected[$];
	bit          patterns_loaded = 1'b0;

	tb_clock #(
		.PERIOD (CLK_PERIOD)
	) u_clock (
		.clk   (clk),
		.reset (reset)
	);

	control_unit DUT (
		.clk         (clk),
		.reset       (reset),
		.irq         (irq),
		.instruction (instruction),
		.fetch_ctrl  (fetch_ctrl),
		.ex_ctrl     (ex_ctrl),
		.mem_ctrl    (mem_ctrl),
		.wb_ctrl     (wb_ctrl)
	);

	task automatic check_value(input string name, input logic [32:0] expected,
		input logic [32:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "output mismatch in %s", name);
		end
	endtask

	task automatic load_patterns();
		int          fd;
		string       header;
		string       name;
		logic [15:0] instr_val;
		logic        irq_val;
		logic [3:0]  fetch_val;
		logic [14:0] ex_val;
		logic [9:0]  mem_val;
		logic [3:0]  wb_val;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0)
		begin
			$display("Some tests failed");
			$fatal(1, "could not open the pattern file %s", PATTERN_FILE);
		end
		else
		begin
			// two header lines describe the columns
			void'($fgets(header, fd));
			void'($fgets(header, fd));
			while ($fscanf(fd, "%s %h %b %h %h %h %h", name, instr_val, irq_val,
				fetch_val, ex_val, mem_val, wb_val) == 7)
			begin
				pat_name.push_back(name);
				pat_instr.push_back(instr_val);
				pat_irq.push_back(irq_val);
				pat_expected.push_back({fetch_val, ex_val, mem_val, wb_val});
			end
			$fclose(fd);
		end
	endtask

	initial
	begin
		instruction <= 16'h4000;
		irq         <= 1'b0;
		load_patterns();
		if (pat_name.size() == 0)
		begin
			$display("Some tests failed");
			$fatal(1, "the pattern file holds no patterns");
		end
		else
		begin
			patterns_loaded = 1'b1;

			// reset window and the first cycle after it
			@(posedge clk);
			while (reset !== 1'b1)
			begin
				@(negedge clk);
				check_value("reset", 33'd0, {30'd0, fetch_ctrl.clear_instruction,
					fetch_ctrl.pc_from_mem, ex_ctrl.flag_restore});
			end

			// one pattern per cycle, sampled just before the next edge
			for (int i = 0; i < pat_name.size(); i++)
			begin
				@(posedge clk);
				instruction <= pat_instr[i];
				irq         <= pat_irq[i];
				#(CLK_PERIOD - 1);
				check_value(pat_name[i], pat_expected[i],
					{fetch_ctrl, ex_ctrl, mem_ctrl, wb_ctrl});
			end

			$display("All tests passed");
			$finish;
		end
	end

	// watchdog, sized from the pattern count
	initial
	begin
		wait (patterns_loaded);
		#((pat_name.size() + 10) * CLK_PERIOD);
		$display("Some tests failed");
		$fatal(1, "the run timed out after %0d patterns", pat_name.size());
	end

endmodule

// File: verif/control_patterns.txt
# name instruction irq fetch ex mem wb, all in hex except irq in binary
# expected bundles are fetch_ctrl 4 bits, ex_ctrl 15, mem_ctrl 10, wb_ctrl 4
after_reset 4000 0 8 7800 000 0
alu_not 0000 0 8 0001 000 c
alu_inc 0845 0 8 0801 000 c
alu_dec 0c12 0 8 1001 000 c
alu_add 1123 0 8 1801 000 c
alu_sub 1800 0 8 2001 000 c
alu_and 2000 0 8 2801 000 c
alu_or 2800 0 8 3001 000 c
alu_shl 3000 0 8 3801 000 c
alu_shr 3800 0 8 4001 000 c
nop 4000 0 8 7800 000 0
setc 4800 0 8 7805 000 0
clrc 5000 0 8 7809 000 0
out 5800 0 8 7800 000 1
in 6000 0 c 7800 000 8
push 6800 0 8 7800 1ac 0
pop 7000 0 8 7800 260 a
one_op_unused 7800 0 8 7800 000 0
mov 8000 0 8 7800 000 c
ldm 8800 0 8 7800 000 8
ldd 9000 0 8 7800 210 a
std_as_nop 9800 0 8 7800 000 0
jz c000 0 8 7840 000 0
jn c800 0 8 7850 000 0
jc d000 0 8 7860 000 0
jmp d800 0 8 7870 000 0
call_push_hi e000 0 8 7870 081 0
call_push_lo 1000 0 0 7800 082 0
call_resume 1000 0 8 1801 000 c
ret_pop e800 0 8 7800 040 0
ret_pop_lo 6800 0 0 7800 040 0
ret_wait0 c000 0 0 7800 000 0
ret_wait1 4800 0 0 7800 000 0
ret_wait2 7000 0 1 7800 000 0
ret_resume 4000 0 8 7800 000 0
reti_start f000 0 8 7800 000 0
reti_pop_flags 1000 0 0 7802 040 0
reti_pop_hi e000 0 0 7800 040 0
reti_pop_lo 6800 0 0 7800 040 0
reti_wait0 e800 0 0 7800 000 0
reti_wait1 f000 0 0 7800 000 0
reti_wait2 9000 0 1 7800 000 0
reti_resume 5800 0 8 7800 000 1
irq_enter 6800 1 2 7800 000 0
irq_drain0 1000 1 2 7800 000 0
irq_drain1 e000 0 2 7800 000 0
irq_drain2 7000 0 2 7800 000 0
irq_drain3 4800 0 2 7800 000 0
irq_drain4 d800 0 2 7800 000 0
irq_push_pc_hi 6800 0 0 7800 081 0
irq_push_pc_lo e800 0 0 7800 082 0
irq_push_flags 0000 0 0 7800 080 0
irq_resume 2000 0 8 2801 000 c
irq_over_call e000 1 2 7800 000 0
irq_call_drain0 e000 0 2 7800 000 0
irq_call_drain1 e000 0 2 7800 000 0
irq_call_drain2 e000 0 2 7800 000 0
irq_call_drain3 e000 0 2 7800 000 0
irq_call_drain4 e000 0 2 7800 000 0
irq_call_push_pc_hi e000 0 0 7800 081 0
irq_call_push_pc_lo e000 0 0 7800 082 0
irq_call_push_flags e000 0 0 7800 080 0
call_after_irq e000 0 8 7870 081 0
call_lo_after_irq 4000 0 0 7800 082 0
final_nop 4000 0 8 7800 000 0

// File: all.f
rtl/ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/flow_sequencer.sv
rtl/control_unit.sv
verif/tb_clock.sv
verif/tb_control_unit.sv
